/* hdl/mvu_pkg.sv */
// Fixed 16-lane unit; precisions must be 1 to 8 and a vcount of 0 stands for 16 vectors
package mvu_pkg;

    localparam int LANES      = 16;
    localparam int PREC_W     = 4;
    localparam int MADDR_W    = 8;
    localparam int VIDX_W     = 4;
    localparam int POPCNT_W   = 5;      // Counts 0 to LANES
    localparam int SHIFT_W    = 4;      // Up to 7 + 7
    localparam int ACC_W      = 24;
    localparam int PIPE_DEPTH = 3;      // Memory read, popcount, result write

    typedef logic [LANES-1:0]        plane_t;
    typedef logic [MADDR_W-1:0]      maddr_t;
    typedef logic [PREC_W-1:0]       prec_t;
    typedef logic [VIDX_W-1:0]       vidx_t;
    typedef logic [POPCNT_W-1:0]     popcnt_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    // Job configuration as the host leaves it in the registers
    typedef struct packed {
        prec_t  iprec;
        prec_t  wprec;
        maddr_t ibase;
        maddr_t wbase;
        vidx_t  vcount;                 // 0 means 16
        logic   d_signed;
        logic   w_signed;
    } job_cfg_t;

    // Travels down the pipeline next to each plane pair
    typedef struct packed {
        logic                 valid;
        logic [SHIFT_W-1:0]   shift;    // Bit significance of the pair
        logic                 neg;      // Pair holds exactly one signed MSB plane
        logic                 first;    // Load instead of accumulate
        logic                 last;     // Final pair of the vector
        vidx_t                vidx;
    } plane_tag_t;

    typedef enum logic [1:0] {IDLE, RUN, DRAIN} ctrl_state_t;

endpackage

/* hdl/mvu_wb_pkg.sv */
// Word-addressed Wishbone classic map; no byte selects, every register is one 32-bit word
package mvu_wb_pkg;

    localparam int WB_ADR_W = 10;
    localparam int WB_DAT_W = 32;

    typedef logic [WB_ADR_W-1:0] wb_adr_t;
    typedef logic [WB_DAT_W-1:0] wb_dat_t;

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;
    } wb_req_t;

    typedef struct packed {
        logic    ack;
        wb_dat_t dat;
    } wb_rsp_t;

    // Register words
    localparam wb_adr_t REG_CTRL   = 10'h000;   // Bit 0 starts a job
    localparam wb_adr_t REG_STATUS = 10'h001;   // Bit 0 busy, bit 1 irq (write 1 clears)
    localparam wb_adr_t REG_IPREC  = 10'h002;
    localparam wb_adr_t REG_WPREC  = 10'h003;
    localparam wb_adr_t REG_IBASE  = 10'h004;
    localparam wb_adr_t REG_WBASE  = 10'h005;
    localparam wb_adr_t REG_VCOUNT = 10'h006;
    localparam wb_adr_t REG_SIGN   = 10'h007;   // Bit 0 data signed, bit 1 weights signed

    // Regions, selected by the two top address bits
    localparam wb_adr_t DMEM_BASE  = 10'h100;
    localparam wb_adr_t WMEM_BASE  = 10'h200;
    localparam wb_adr_t RES_BASE   = 10'h300;

endpackage

/* hdl/mvu_bitplane_mem.sv */
// Contents are undefined after power-up and untouched by reset; read data lags by one cycle
`timescale 1ns/1ps

module mvu_bitplane_mem import mvu_pkg::*; #(
    parameter int DEPTH = 256
) (
    input  logic   mvu_ext,
    input  logic   we,
    input  maddr_t waddr,
    input  plane_t wdata,
    input  maddr_t raddr,
    output plane_t rdata
);

    plane_t mem [DEPTH];

    always_ff @(posedge mvu_ext) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];        // Old word on a same-address write
    end

endmodule

/* hdl/mvu_vvp.sv */
// Two register stages; the tag is delayed to line up with memory data and then popcount
`timescale 1ns/1ps

module mvu_vvp import mvu_pkg::*; (
    input  logic       mvu_ext,
    input  logic       reset,
    input  plane_t     dplane,
    input  plane_t     wplane,
    input  plane_tag_t tag_in,
    output popcnt_t    popcnt,
    output plane_tag_t tag_out
);

    plane_tag_t tag_q;              // Matches the memory read latency
    plane_t     match;
    popcnt_t    ones;

    assign match = dplane & wplane;

    always_comb begin
        ones = '0;
        for (int i = 0; i < LANES; i++) begin
            ones = ones + popcnt_t'(match[i]);
        end
    end

    always_ff @(posedge mvu_ext) begin
        if (reset) begin
            tag_q   <= '0;
            tag_out <= '0;
        end else begin
            tag_q   <= tag_in;
            tag_out <= tag_q;
        end
    end

    always_ff @(posedge mvu_ext) begin
        popcnt <= ones;
    end

endmodule

/* hdl/mvu_shacc.sv */
// Results are only valid once the job that produced them has raised irq
`timescale 1ns/1ps

module mvu_shacc import mvu_pkg::*; (
    input  logic       mvu_ext,
    input  logic       reset,
    input  popcnt_t    popcnt,
    input  plane_tag_t tag,
    input  vidx_t      res_raddr,
    output acc_t       res_rdata
);

    acc_t acc;
    acc_t term;
    acc_t sum;
    acc_t res_mem [1 << VIDX_W];

    always_comb begin
        term = acc_t'(popcnt) <<< tag.shift;
        if (tag.neg) begin
            term = -term;           // Signed MSB plane carries negative weight
        end
        sum = tag.first ? term : acc + term;
    end

    always_ff @(posedge mvu_ext) begin
        if (reset) begin
            acc <= '0;
        end else if (tag.valid) begin
            acc <= sum;
        end
    end

    always_ff @(posedge mvu_ext) begin
        if (tag.valid && tag.last) begin
            res_mem[tag.vidx] <= sum;   // Finished dot product
        end
    end

    assign res_rdata = res_mem[res_raddr];

endmodule

/* hdl/mvu_inagu.sv */
// Assumes a nonzero precision; counters only wrap cleanly when a job runs to its end
`timescale 1ns/1ps

module mvu_inagu import mvu_pkg::*; #(
    parameter int DMEM_DEPTH = 256,
    parameter int WMEM_DEPTH = 256
) (
    input  logic       mvu_ext,
    input  logic       reset,
    input  logic       step,
    input  job_cfg_t   job_cfg,
    output maddr_t     daddr,
    output maddr_t     waddr,
    output plane_tag_t tag
);

    typedef logic [MADDR_W:0] wide_addr_t;     // Spare bit exposes a wrap past the top

    prec_t      p;                  // Data plane, 0 is the MSB
    prec_t      q;                  // Weight plane, 0 is the MSB
    vidx_t      k;                  // Weight vector
    logic       p_end;
    logic       q_end;
    logic       k_end;
    wide_addr_t daddr_full;
    wide_addr_t waddr_full;

    assign p_end = (p == job_cfg.iprec - 1'b1);
    assign q_end = (q == job_cfg.wprec - 1'b1);
    assign k_end = (k == job_cfg.vcount - 1'b1);   // Wraps to 15 for a vcount of 16

    always_ff @(posedge mvu_ext) begin
        if (reset) begin
            p <= '0;
            q <= '0;
            k <= '0;
        end else if (step) begin
            if (q_end) begin
                q <= '0;
                if (p_end) begin
                    p <= '0;
                    k <= k_end ? '0 : k + 1'b1;     // Back to zero for the next job
                end else begin
                    p <= p + 1'b1;
                end
            end else begin
                q <= q + 1'b1;
            end
        end
    end

    assign daddr_full = wide_addr_t'(job_cfg.ibase) + wide_addr_t'(p);
    assign waddr_full = wide_addr_t'(job_cfg.wbase) + wide_addr_t'(k) * wide_addr_t'(job_cfg.wprec)
                      + wide_addr_t'(q);
    assign daddr = maddr_t'(daddr_full);
    assign waddr = maddr_t'(waddr_full);

    always_comb begin
        tag.valid = step;
        tag.shift = (job_cfg.iprec - 1'b1 - p) + (job_cfg.wprec - 1'b1 - q);
        tag.neg   = (job_cfg.d_signed && p == '0) ^ (job_cfg.w_signed && q == '0);
        tag.first = (p == '0) && (q == '0);
        tag.last  = p_end && q_end;
        tag.vidx  = k;
    end

    a_addr_in_range: assert property (@(posedge mvu_ext) disable iff (reset)
        step |-> (daddr_full < DMEM_DEPTH) && (waddr_full < WMEM_DEPTH));

endmodule

/* hdl/mvu_controller.sv */
// A start arriving while a job runs is dropped; irq stays set until the host clears it
`timescale 1ns/1ps

module mvu_controller import mvu_pkg::*; (
    input  logic     mvu_ext,
    input  logic     reset,
    input  logic     start,
    input  job_cfg_t cfg_in,
    input  logic     irq_clr,
    output logic     step,
    output job_cfg_t job_cfg,
    output logic     busy,
    output logic     irq
);

    localparam int CNT_W = 11;      // Up to 8 x 8 x 16 steps

    typedef logic [CNT_W-1:0] cnt_t;

    ctrl_state_t     state;
    cnt_t            cnt;           // Steps or drain cycles left, minus one
    cnt_t            job_steps;
    logic [VIDX_W:0] vcnt;

    assign vcnt      = {cfg_in.vcount == '0, cfg_in.vcount};   // Stored 0 becomes 16
    assign job_steps = cnt_t'(cfg_in.iprec) * cnt_t'(cfg_in.wprec) * cnt_t'(vcnt);
    assign busy      = (state != IDLE);

    always_ff @(posedge mvu_ext) begin
        if (reset) begin
            state   <= IDLE;
            step    <= 1'b0;
            irq     <= 1'b0;
            cnt     <= '0;
            job_cfg <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state   <= RUN;
                        step    <= 1'b1;
                        job_cfg <= cfg_in;
                        cnt     <= job_steps - 1'b1;
                    end
                end
                RUN: begin
                    if (cnt == '0) begin
                        state <= DRAIN;
                        step  <= 1'b0;
                        cnt   <= cnt_t'(PIPE_DEPTH - 1);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                DRAIN: begin
                    if (cnt == '0) begin
                        state <= IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase

            if (state == DRAIN && cnt == '0) begin
                irq <= 1'b1;                        // Set wins over a clear
            end else if (irq_clr) begin
                irq <= 1'b0;
            end
        end
    end

    // Steps run only in RUN and only for precisions of 1 to 8
    a_step_in_run: assert property (@(posedge mvu_ext) disable iff (reset)
        step |-> (state == RUN) && (job_cfg.iprec != '0) && (job_cfg.iprec <= 4'd8)
                 && (job_cfg.wprec != '0) && (job_cfg.wprec <= 4'd8));

endmodule

/* hdl/mvu_wb_regs.sv */
// Result reads alias every 16 words of the result region; memory regions are write only
`timescale 1ns/1ps

module mvu_wb_regs import mvu_pkg::*, mvu_wb_pkg::*; (
    input  logic     mvu_ext,
    input  logic     reset,
    input  wb_req_t  wb_req,
    output wb_rsp_t  wb_rsp,
    output logic     start,
    output job_cfg_t cfg,
    input  logic     busy,
    input  logic     irq,
    output logic     irq_clr,
    output logic     dmem_we,
    output logic     wmem_we,
    output maddr_t   mem_waddr,
    output plane_t   mem_wdata,
    output vidx_t    res_raddr,
    input  acc_t     res_rdata
);

    logic    ack_q;
    wb_dat_t rdat_q;
    wb_dat_t rdat_d;
    logic    req;                   // New transaction seen this cycle
    logic    wr;
    logic    in_dmem;
    logic    in_wmem;
    logic    in_res;
    prec_t   iprec_q;
    prec_t   wprec_q;
    maddr_t  ibase_q;
    maddr_t  wbase_q;
    vidx_t   vcount_q;
    logic [1:0] sign_q;

    assign req     = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr      = req && wb_req.we;
    assign in_dmem = (wb_req.adr[9:8] == DMEM_BASE[9:8]);
    assign in_wmem = (wb_req.adr[9:8] == WMEM_BASE[9:8]);
    assign in_res  = (wb_req.adr[9:8] == RES_BASE[9:8]);

    assign res_raddr = vidx_t'(wb_req.adr);
    assign wb_rsp    = '{ack: ack_q, dat: rdat_q};

    assign cfg = '{iprec: iprec_q, wprec: wprec_q, ibase: ibase_q, wbase: wbase_q,
                   vcount: vcount_q, d_signed: sign_q[0], w_signed: sign_q[1]};

    always_comb begin
        rdat_d = '0;
        case (wb_req.adr)
            REG_STATUS: rdat_d = wb_dat_t'({irq, busy});
            REG_IPREC:  rdat_d = wb_dat_t'(iprec_q);
            REG_WPREC:  rdat_d = wb_dat_t'(wprec_q);
            REG_IBASE:  rdat_d = wb_dat_t'(ibase_q);
            REG_WBASE:  rdat_d = wb_dat_t'(wbase_q);
            REG_VCOUNT: rdat_d = wb_dat_t'(vcount_q);
            REG_SIGN:   rdat_d = wb_dat_t'(sign_q);
            default: begin
                if (in_res) begin
                    rdat_d = {{(WB_DAT_W-ACC_W){res_rdata[ACC_W-1]}}, res_rdata};  // Sign extend
                end
            end
        endcase
    end

    // Ack and all write side effects land in the same cycle
    always_ff @(posedge mvu_ext) begin
        if (reset) begin
            ack_q    <= 1'b0;
            start    <= 1'b0;
            irq_clr  <= 1'b0;
            dmem_we  <= 1'b0;
            wmem_we  <= 1'b0;
            iprec_q  <= '0;
            wprec_q  <= '0;
            ibase_q  <= '0;
            wbase_q  <= '0;
            vcount_q <= '0;
            sign_q   <= '0;
        end else begin
            ack_q   <= req;
            start   <= wr && (wb_req.adr == REG_CTRL) && wb_req.dat[0];
            irq_clr <= wr && (wb_req.adr == REG_STATUS) && wb_req.dat[1];
            dmem_we <= wr && in_dmem;
            wmem_we <= wr && in_wmem;
            if (wr) begin
                case (wb_req.adr)
                    REG_IPREC:  iprec_q  <= prec_t'(wb_req.dat);
                    REG_WPREC:  wprec_q  <= prec_t'(wb_req.dat);
                    REG_IBASE:  ibase_q  <= maddr_t'(wb_req.dat);
                    REG_WBASE:  wbase_q  <= maddr_t'(wb_req.dat);
                    REG_VCOUNT: vcount_q <= vidx_t'(wb_req.dat);
                    REG_SIGN:   sign_q   <= wb_req.dat[1:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge mvu_ext) begin
        if (req) begin
            mem_waddr <= maddr_t'(wb_req.adr);
            mem_wdata <= wb_req.dat[LANES-1:0];
            rdat_q    <= rdat_d;
        end
    end

    // Master must hold stb until it sees the ack
    a_ack_with_stb: assert property (@(posedge mvu_ext) disable iff (reset)
        wb_rsp.ack |-> wb_req.stb);

endmodule

/* hdl/mvu_top.sv */
// Single matrix-vector unit behind a Wishbone classic slave; both memories use 8-bit addresses
`timescale 1ns/1ps

module mvu_top import mvu_pkg::*, mvu_wb_pkg::*; #(
    parameter int DMEM_DEPTH = 256,
    parameter int WMEM_DEPTH = 256
) (
    input  logic    mvu_ext,
    input  logic    reset,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp,
    output logic    irq
);

    logic       start;
    logic       busy;
    logic       irq_clr;
    logic       step;
    logic       dmem_we;
    logic       wmem_we;
    maddr_t     mem_waddr;
    plane_t     mem_wdata;
    maddr_t     daddr;
    maddr_t     waddr;
    plane_t     dplane;
    plane_t     wplane;
    job_cfg_t   cfg;            // As held in the registers
    job_cfg_t   job_cfg;        // Latched at start
    plane_tag_t step_tag;
    plane_tag_t acc_tag;
    popcnt_t    popcnt;
    vidx_t      res_raddr;
    acc_t       res_rdata;

    mvu_wb_regs regs (
        .mvu_ext   (mvu_ext),
        .reset     (reset),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .start     (start),
        .cfg       (cfg),
        .busy      (busy),
        .irq       (irq),
        .irq_clr   (irq_clr),
        .dmem_we   (dmem_we),
        .wmem_we   (wmem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .res_raddr (res_raddr),
        .res_rdata (res_rdata)
    );

    mvu_controller ctrl (
        .mvu_ext (mvu_ext),
        .reset   (reset),
        .start   (start),
        .cfg_in  (cfg),
        .irq_clr (irq_clr),
        .step    (step),
        .job_cfg (job_cfg),
        .busy    (busy),
        .irq     (irq)
    );

    mvu_inagu #(
        .DMEM_DEPTH (DMEM_DEPTH),
        .WMEM_DEPTH (WMEM_DEPTH)
    ) inagu (
        .mvu_ext (mvu_ext),
        .reset   (reset),
        .step    (step),
        .job_cfg (job_cfg),
        .daddr   (daddr),
        .waddr   (waddr),
        .tag     (step_tag)
    );

    mvu_bitplane_mem #(.DEPTH(DMEM_DEPTH)) dmem (
        .mvu_ext (mvu_ext),
        .we      (dmem_we),
        .waddr   (mem_waddr),
        .wdata   (mem_wdata),
        .raddr   (daddr),
        .rdata   (dplane)
    );

    mvu_bitplane_mem #(.DEPTH(WMEM_DEPTH)) wmem (
        .mvu_ext (mvu_ext),
        .we      (wmem_we),
        .waddr   (mem_waddr),
        .wdata   (mem_wdata),
        .raddr   (waddr),
        .rdata   (wplane)
    );

    mvu_vvp vvp (
        .mvu_ext (mvu_ext),
        .reset   (reset),
        .dplane  (dplane),
        .wplane  (wplane),
        .tag_in  (step_tag),
        .popcnt  (popcnt),
        .tag_out (acc_tag)
    );

    mvu_shacc shacc (
        .mvu_ext   (mvu_ext),
        .reset     (reset),
        .popcnt    (popcnt),
        .tag       (acc_tag),
        .res_raddr (res_raddr),
        .res_rdata (res_rdata)
    );

endmodule

/* verification/mvu_tb_model.svh */
// Reference model for the testbench; two job slots of at most 16 vectors, elements of 1 to 8 bits
`ifndef MVU_TB_MODEL_SVH
`define MVU_TB_MODEL_SVH

localparam int FILL_RANDOM = 0;
localparam int FILL_ONES   = 1;         // Every element all ones
localparam int FILL_MIN    = 2;         // Only the MSB set, most negative when signed

int unsigned rng_state = 83;
int unsigned dval [2][LANES];           // Raw data elements per slot
int unsigned wval [2][16][LANES];       // Raw weight elements per slot and vector

function automatic int unsigned lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
endfunction

function automatic int rand_range(int lo, int hi);
    return lo + int'((lcg_next() >> 8) % (hi - lo + 1));
endfunction

function automatic wb_dat_t rand_word();
    int unsigned a;
    int unsigned b;
    a = lcg_next();
    b = lcg_next();
    return {a[31:16], b[31:16]};        // Upper halves have the better period
endfunction

function automatic int vlen(job_cfg_t c);
    return (c.vcount == 0) ? 16 : int'(c.vcount);
endfunction

function automatic int unsigned fill_value(int mode, int prec);
    case (mode)
        FILL_ONES: return (1 << prec) - 1;
        FILL_MIN:  return 1 << (prec - 1);
        default:   return (lcg_next() >> 8) & ((1 << prec) - 1);
    endcase
endfunction

function automatic void fill_slot(int slot, job_cfg_t c, int mode);
    for (int i = 0; i < LANES; i++) begin
        dval[slot][i] = fill_value(mode, c.iprec);
        for (int k = 0; k < 16; k++) begin
            wval[slot][k][i] = fill_value(mode, c.wprec);
        end
    end
endfunction

// Lane i of the plane holds one bit of element i; plane 0 is the MSB
function automatic plane_t pack_plane(int slot, bit is_w, int k, int prec, int p);
    plane_t      pl;
    int unsigned v;
    for (int i = 0; i < LANES; i++) begin
        v = is_w ? wval[slot][k][i] : dval[slot][i];
        pl[i] = v[prec - 1 - p];
    end
    return pl;
endfunction

function automatic int as_signed(int unsigned raw, int prec, bit sgn);
    int v;
    v = int'(raw);
    if (sgn && raw[prec - 1]) begin
        v = v - (1 << prec);            // Two's complement
    end
    return v;
endfunction

function automatic acc_t model_dot(int slot, int k, job_cfg_t c);
    int sum;
    sum = 0;
    for (int i = 0; i < LANES; i++) begin
        sum += as_signed(dval[slot][i], c.iprec, c.d_signed)
             * as_signed(wval[slot][k][i], c.wprec, c.w_signed);
    end
    return acc_t'(sum);
endfunction

`endif

/* verification/mvu_tb.sv */
// Runs fixed-seed LCG jobs over Wishbone and compares with the model; memories hold 256 planes each
`timescale 1ns/1ps

module mvu_tb import mvu_pkg::*, mvu_wb_pkg::*; ();

    localparam int NJOBS = 14;

    logic     mvu_ext;
    logic     reset;
    wb_req_t  wb_req;
    wb_rsp_t  wb_rsp;
    logic     irq;
    job_cfg_t plan_cfg [NJOBS];
    int       plan_fill [NJOBS];
    int       cycles = 0;
    int       cycle_limit = 0;
    int       checks = 0;
    int       errors = 0;
    int       test_errors = 0;
    string    cur_test;

    `include "mvu_tb_model.svh"

    mvu_top #(
        .DMEM_DEPTH (256),
        .WMEM_DEPTH (256)
    ) dut (
        .mvu_ext (mvu_ext),
        .reset   (reset),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .irq     (irq)
    );

    initial begin
        mvu_ext = 1'b0;
        forever #20 mvu_ext = ~mvu_ext;
    end

    always @(posedge mvu_ext) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // Called on a falling edge; returns on the falling edge after ack has been sampled
    task automatic bus_access(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                              output wb_dat_t rdat);
        int waited;
        waited = 0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        @(negedge mvu_ext);
        while (!wb_rsp.ack && waited < 4) begin
            waited++;
            @(negedge mvu_ext);
        end
        if (!wb_rsp.ack) begin
            $display("Bus error, no ack from the slave for address 0x%03h", adr);
            $display("Test failed");
            $finish;
        end else begin
            rdat = wb_rsp.dat;
            @(negedge mvu_ext);             // Hold stb through the edge that sees ack
            wb_req = '0;
            if (wb_rsp.ack) begin
                errors++;
                test_errors++;
                $display("Slave held ack longer than one cycle for address 0x%03h", adr);
            end
        end
    endtask

    task automatic bus_write(input wb_adr_t adr, input wb_dat_t dat);
        wb_dat_t unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic bus_read(input wb_adr_t adr, output wb_dat_t dat);
        bus_access(1'b0, adr, '0, dat);
    endtask

    task automatic check_word(input wb_dat_t exp, input wb_dat_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("ERR %s expected 0x%08h actual 0x%08h", cur_test, exp, act);
        end
    endtask

    task automatic check_result(input acc_t exp, input acc_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("ERR %s expected %0d actual %0d", cur_test, exp, act);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("test %s done, %0d errors", cur_test, test_errors);
    endtask

    function automatic wb_dat_t field_mask(wb_adr_t adr);
        case (adr)
            REG_IBASE, REG_WBASE: return 32'hff;
            REG_SIGN:             return 32'h3;
            default:              return 32'hf;
        endcase
    endfunction

    // Zero arguments are drawn at random; half picks the low or high half of both memories
    function automatic job_cfg_t random_job(int ip, int wp, int vc, bit ds, bit ws, int half);
        job_cfg_t c;
        int       span;
        int       lo;
        if (ip == 0) ip = rand_range(1, 8);
        if (wp == 0) wp = rand_range(1, 8);
        if (vc == 0) vc = rand_range(1, 16);
        span       = (half < 0) ? 256 : 128;
        lo         = (half > 0) ? 128 : 0;
        c.iprec    = prec_t'(ip);
        c.wprec    = prec_t'(wp);
        c.vcount   = vidx_t'(vc);           // 16 is stored as 0
        c.ibase    = maddr_t'(lo + rand_range(0, span - ip));
        c.wbase    = maddr_t'(lo + rand_range(0, span - vc * wp));
        c.d_signed = ds;
        c.w_signed = ws;
        return c;
    endfunction

    function automatic void plan_jobs();
        for (int j = 0; j < NJOBS; j++) begin
            plan_fill[j] = FILL_RANDOM;
        end
        plan_cfg[0]  = random_job(0, 0, 0, 1'b0, 1'b0, -1);
        plan_cfg[1]  = random_job(0, 0, 0, 1'b0, 1'b0, -1);
        plan_cfg[2]  = random_job(0, 0, 0, 1'b0, 1'b0, -1);
        plan_cfg[3]  = random_job(0, 0, 0, 1'b1, 1'b0, -1);
        plan_cfg[4]  = random_job(0, 0, 0, 1'b0, 1'b1, -1);
        plan_cfg[5]  = random_job(0, 0, 0, 1'b1, 1'b1, -1);
        plan_cfg[6]  = random_job(1, 1, 16, 1'b0, 1'b0, -1);
        plan_cfg[7]  = random_job(1, 1, 7, 1'b1, 1'b1, -1);
        plan_cfg[8]  = random_job(8, 8, 3, 1'b0, 1'b0, -1);
        plan_cfg[9]  = random_job(8, 8, 2, 1'b1, 1'b1, -1);
        plan_cfg[10] = random_job(1, 8, 5, 1'b0, 1'b1, -1);
        plan_cfg[11] = random_job(8, 8, 4, 1'b1, 1'b0, -1);    // Long enough to start into
        plan_cfg[12] = random_job(0, 0, 0, 1'b0, 1'b1, 0);
        plan_cfg[13] = random_job(0, 0, 0, 1'b1, 1'b1, 1);
        plan_fill[6]  = FILL_ONES;
        plan_fill[7]  = FILL_MIN;
        plan_fill[8]  = FILL_ONES;
        plan_fill[9]  = FILL_MIN;
        plan_fill[10] = FILL_MIN;
    endfunction

    function automatic int job_budget(job_cfg_t c);
        int n;
        int accesses;
        n = vlen(c);
        accesses = 9 + int'(c.iprec) + n * int'(c.wprec) + n;
        return int'(c.iprec) * int'(c.wprec) * n + PIPE_DEPTH + 20 + 8 * accesses;
    endfunction

    task automatic load_slot(input int slot, input job_cfg_t c);
        for (int p = 0; p < c.iprec; p++) begin
            bus_write(wb_adr_t'(DMEM_BASE + c.ibase + p),
                      wb_dat_t'(pack_plane(slot, 1'b0, 0, c.iprec, p)));
        end
        for (int k = 0; k < vlen(c); k++) begin
            for (int q = 0; q < c.wprec; q++) begin
                bus_write(wb_adr_t'(WMEM_BASE + c.wbase + k * c.wprec + q),
                          wb_dat_t'(pack_plane(slot, 1'b1, k, c.wprec, q)));
            end
        end
    endtask

    task automatic start_job(input job_cfg_t c);
        bus_write(REG_IPREC, wb_dat_t'(c.iprec));
        bus_write(REG_WPREC, wb_dat_t'(c.wprec));
        bus_write(REG_IBASE, wb_dat_t'(c.ibase));
        bus_write(REG_WBASE, wb_dat_t'(c.wbase));
        bus_write(REG_VCOUNT, wb_dat_t'(c.vcount));
        bus_write(REG_SIGN, wb_dat_t'({c.w_signed, c.d_signed}));
        bus_write(REG_CTRL, 32'h1);
    endtask

    task automatic finish_job();
        wb_dat_t st;
        st = 32'h1;
        while (st[0]) begin
            bus_read(REG_STATUS, st);
        end
        check_word(32'h2, st);                  // Idle with irq pending
        check_word(32'h1, wb_dat_t'(irq));
        bus_write(REG_STATUS, 32'h2);
        check_word(32'h0, wb_dat_t'(irq));
    endtask

    task automatic check_results(input int slot, input job_cfg_t c);
        wb_dat_t rd;
        acc_t    exp;
        for (int k = 0; k < vlen(c); k++) begin
            exp = model_dot(slot, k, c);
            bus_read(wb_adr_t'(RES_BASE + k), rd);
            check_result(exp, acc_t'(rd));
            check_word(wb_dat_t'(exp), rd);     // Full bus word, sign extended
        end
    endtask

    task automatic run_planned(input int j);
        fill_slot(0, plan_cfg[j], plan_fill[j]);
        load_slot(0, plan_cfg[j]);
        start_job(plan_cfg[j]);
        finish_job();
        check_results(0, plan_cfg[j]);
    endtask

    task automatic register_test();
        wb_dat_t written [6];
        wb_dat_t rd;
        begin_test("regs");
        bus_read(REG_STATUS, rd);
        check_word(32'h0, rd);
        check_word(32'h0, wb_dat_t'(irq));
        for (int r = 0; r < 6; r++) begin
            written[r] = rand_word();
            bus_write(wb_adr_t'(REG_IPREC + r), written[r]);
        end
        for (int r = 0; r < 6; r++) begin
            bus_read(wb_adr_t'(REG_IPREC + r), rd);
            check_word(written[r] & field_mask(wb_adr_t'(REG_IPREC + r)), rd);
        end
        bus_read(REG_CTRL, rd);
        check_word(32'h0, rd);
        bus_read(wb_adr_t'(DMEM_BASE + 5), rd);
        check_word(32'h0, rd);
        end_test();
    endtask

    initial begin
        wb_dat_t rd;
        reset  = 1'b1;
        wb_req = '0;
        plan_jobs();
        for (int j = 0; j < NJOBS; j++) begin
            cycle_limit += job_budget(plan_cfg[j]);
        end
        cycle_limit = 2 * (cycle_limit + 8 * 18 + 16);    // Register test, busy start, reset
        repeat (16) @(negedge mvu_ext);
        reset = 1'b0;

        register_test();

        begin_test("unsigned");
        for (int j = 0; j < 3; j++) begin
            run_planned(j);
        end
        end_test();

        begin_test("signed");
        for (int j = 3; j < 6; j++) begin
            run_planned(j);
        end
        end_test();

        begin_test("extremes");
        for (int j = 6; j < 11; j++) begin
            run_planned(j);
        end
        end_test();

        begin_test("irq");
        fill_slot(0, plan_cfg[11], plan_fill[11]);
        load_slot(0, plan_cfg[11]);
        start_job(plan_cfg[11]);
        bus_read(REG_STATUS, rd);
        check_word(32'h1, rd);                  // Busy, no irq yet
        bus_write(REG_CTRL, 32'h1);             // Second start lands mid job
        finish_job();
        check_results(0, plan_cfg[11]);
        repeat (8 * 8 * vlen(plan_cfg[11]) + PIPE_DEPTH + 8) @(negedge mvu_ext);
        check_word(32'h0, wb_dat_t'(irq));
        bus_read(REG_STATUS, rd);
        check_word(32'h0, rd);
        end_test();

        // Both data sets stay resident while the two jobs run
        begin_test("back_to_back");
        fill_slot(0, plan_cfg[12], FILL_RANDOM);
        fill_slot(1, plan_cfg[13], FILL_RANDOM);
        load_slot(0, plan_cfg[12]);
        load_slot(1, plan_cfg[13]);
        start_job(plan_cfg[12]);
        finish_job();
        check_results(0, plan_cfg[12]);
        start_job(plan_cfg[13]);
        finish_job();
        check_results(1, plan_cfg[13]);
        end_test();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* mvu_top.f */
+incdir+verification
hdl/mvu_pkg.sv
hdl/mvu_wb_pkg.sv
hdl/mvu_bitplane_mem.sv
hdl/mvu_vvp.sv
hdl/mvu_shacc.sv
hdl/mvu_inagu.sv
hdl/mvu_controller.sv
hdl/mvu_wb_regs.sv
hdl/mvu_top.sv
verification/mvu_tb.sv
